// File: logic/rename_pkg.sv
package rename_pkg;

    localparam int PHYS_REG_BITS = 6;
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // base opcodes of rv32im
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    // one instruction word, seen as register format or store format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_view;
    } inst_word_u;

    typedef struct packed {
        inst_word_u  inst;
        logic [31:0] pc;
    } fetch_pkt_t;

    // reservation station kind
    typedef enum logic [2:0] {
        cls_alu    = 3'd0,
        cls_mul    = 3'd1,
        cls_div    = 3'd2,
        cls_branch = 3'd3,
        cls_mem    = 3'd4
    } rs_class_e;

    typedef struct packed {
        inst_word_u               inst;
        logic [31:0]              pc;
        logic [63:0]              order;
        rs_class_e                rs_class;
        logic [31:0]              imm;
        logic [4:0]               rd_arch;
        logic [PHYS_REG_BITS-1:0] pd;
        logic [PHYS_REG_BITS-1:0] old_pd;
        logic [PHYS_REG_BITS-1:0] ps1;
        logic [PHYS_REG_BITS-1:0] ps2;
        logic                     writes_rd;
    } dispatch_pkt_t;

endpackage

// File: logic/inst_queue.sv
`timescale 1ns/100ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    output logic                   fetch_ack,
    input  rename_pkg::fetch_pkt_t fetch_pkt,
    input  logic                   pop,
    output rename_pkg::fetch_pkt_t head,
    output logic                   not_empty
);
    import rename_pkg::*;

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    fetch_pkt_t          ring [QUEUE_DEPTH];
    fetch_pkt_t          in_pkt;
    logic                in_valid;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                full;
    logic                accept;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CNT_BITS'(QUEUE_DEPTH));
    assign not_empty = (count != '0);
    assign head      = ring[rd_ptr];

    // only a fresh req phase with ack still low is taken
    assign accept = fetch_req && !fetch_ack && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ack <= 1'b0;
            in_valid  <= 1'b0;
        end else begin
            if (accept)
                fetch_ack <= 1'b1;
            else if (fetch_ack && !fetch_req)
                fetch_ack <= 1'b0;
            in_valid <= accept;
        end
    end

    // holding stage, pushed into the ring one cycle later
    always_ff @(posedge clk) begin
        if (accept)
            in_pkt <= fetch_pkt;
        if (in_valid)
            ring[wr_ptr] <= in_pkt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/free_list.sv
`timescale 1ns/100ps

module free_list (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc,
    input  logic                               release_en,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] release_preg,
    output logic [rename_pkg::PHYS_REG_BITS-1:0] head_preg,
    output logic                               has_free
);
    import rename_pkg::*;

    // registers beyond the architectural ones start out free
    localparam int FREE_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;
    localparam int PTR_BITS   = $clog2(FREE_DEPTH);

    logic [PHYS_REG_BITS-1:0] ring [FREE_DEPTH];
    logic [PTR_BITS-1:0]      rd_ptr;
    logic [PTR_BITS-1:0]      wr_ptr;
    logic [PTR_BITS:0]        count;

    assign head_preg = ring[rd_ptr];
    assign has_free  = (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_DEPTH; i++)
                ring[i] <= PHYS_REG_BITS'(NUM_ARCH_REGS + i);
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= (PTR_BITS + 1)'(FREE_DEPTH);
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (alloc)
                rd_ptr <= rd_ptr + 1'b1;
            if (release_en) begin
                ring[wr_ptr] <= release_preg;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            case ({alloc, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/rename_table.sv
`timescale 1ns/100ps

module rename_table (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [4:0]                           rs1,
    input  logic [4:0]                           rs2,
    input  logic [4:0]                           rd,
    output logic [rename_pkg::PHYS_REG_BITS-1:0] ps1,
    output logic [rename_pkg::PHYS_REG_BITS-1:0] ps2,
    output logic [rename_pkg::PHYS_REG_BITS-1:0] old_pd,
    input  logic                                 map_we,
    input  logic [4:0]                           map_rd,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] map_pd
);
    import rename_pkg::*;

    logic [PHYS_REG_BITS-1:0] map [NUM_ARCH_REGS];

    assign ps1    = map[rs1];
    assign ps2    = map[rs2];
    assign old_pd = map[rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping, x0 stays on p0
            for (int i = 0; i < NUM_ARCH_REGS; i++)
                map[i] <= PHYS_REG_BITS'(i);
        end else if (map_we && map_rd != 5'd0) begin
            map[map_rd] <= map_pd;
        end
    end

endmodule

// File: logic/rename_dispatch.sv
`timescale 1ns/100ps

module rename_dispatch (
    input  logic                                 clk,
    input  logic                                 rst,
    input  rename_pkg::fetch_pkt_t               head,
    input  logic                                 not_empty,
    output logic                                 pop,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] head_preg,
    input  logic                                 has_free,
    output logic                                 alloc,
    output logic [4:0]                           rs1,
    output logic [4:0]                           rs2,
    output logic [4:0]                           rd,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] ps1,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] ps2,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] old_pd,
    output logic                                 map_we,
    output logic [4:0]                           map_rd,
    output logic [rename_pkg::PHYS_REG_BITS-1:0] map_pd,
    input  logic                                 idle,
    output logic                                 load,
    output rename_pkg::dispatch_pkt_t            pkt
);
    import rename_pkg::*;

    inst_word_u  inst;
    logic [6:0]  opcode;
    rs_class_e   rs_class;
    logic [31:0] imm;
    logic        writes_rd;
    logic        fire;
    logic [63:0] order;

    assign inst   = head.inst;
    assign opcode = inst.r_view.opcode;
    assign rs1    = inst.r_view.rs1;
    assign rs2    = inst.r_view.rs2;
    assign rd     = inst.r_view.rd;

    assign writes_rd = (inst.r_view.rd != 5'd0) && (opcode != op_store) && (opcode != op_br);

    // station kind, m extension splits on funct3 bit 2
    always_comb begin
        rs_class = cls_alu;
        case (opcode)
            op_reg: begin
                if (inst.r_view.funct7 == 7'b0000001)
                    rs_class = inst.r_view.funct3[2] ? cls_div : cls_mul;
            end
            op_br, op_jal, op_jalr: rs_class = cls_branch;
            op_load, op_store:      rs_class = cls_mem;
            default:                rs_class = cls_alu;
        endcase
    end

    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr:
                imm = {{20{inst.r_view.funct7[6]}}, inst.r_view.funct7, inst.r_view.rs2};
            op_store:
                imm = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
            op_br:
                imm = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_lo[0],
                       inst.s_view.imm_hi[5:0], inst.s_view.imm_lo[4:1], 1'b0};
            op_lui, op_auipc:
                imm = {inst.r_view.funct7, inst.r_view.rs2, inst.r_view.rs1,
                       inst.r_view.funct3, 12'h000};
            op_jal:
                imm = {{12{inst.r_view.funct7[6]}}, inst.r_view.rs1, inst.r_view.funct3,
                       inst.r_view.rs2[0], inst.r_view.funct7[5:0], inst.r_view.rs2[4:1], 1'b0};
            default:
                imm = 32'd0;
        endcase
    end

    // a non-writing instruction never waits on the free list
    assign fire   = not_empty && idle && (has_free || !writes_rd);
    assign pop    = fire;
    assign load   = fire;
    assign alloc  = fire && writes_rd;
    assign map_we = alloc;
    assign map_rd = inst.r_view.rd;
    assign map_pd = head_preg;

    always_comb begin
        pkt.inst      = inst;
        pkt.pc        = head.pc;
        pkt.order     = order;
        pkt.rs_class  = rs_class;
        pkt.imm       = imm;
        pkt.rd_arch   = inst.r_view.rd;
        pkt.pd        = writes_rd ? head_preg : '0;
        pkt.old_pd    = writes_rd ? old_pd : '0;
        pkt.ps1       = ps1;
        pkt.ps2       = ps2;
        pkt.writes_rd = writes_rd;
    end

    always_ff @(posedge clk) begin
        if (rst)
            order <= 64'd0;
        else if (fire)
            order <= order + 64'd1;
    end

endmodule

// File: logic/dispatch_port.sv
`timescale 1ns/100ps

module dispatch_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  rename_pkg::dispatch_pkt_t pkt,
    output logic                      idle,
    output logic                      disp_req,
    input  logic                      disp_ack,
    output rename_pkg::dispatch_pkt_t disp_pkt
);
    import rename_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_low
    } port_state_e;

    port_state_e   state;
    dispatch_pkt_t pkt_q;

    assign idle     = (state == st_idle);
    assign disp_req = (state == st_req);
    assign disp_pkt = pkt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:     if (load) state <= st_req;
                st_req:      if (disp_ack) state <= st_wait_low;
                // back end must release ack before the next packet
                st_wait_low: if (!disp_ack) state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load && state == st_idle)
            pkt_q <= pkt;
    end

endmodule

// File: logic/rename_top.sv
`timescale 1ns/100ps

module rename_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fetch_req,
    output logic                                 fetch_ack,
    input  rename_pkg::fetch_pkt_t               fetch_pkt,
    output logic                                 disp_req,
    input  logic                                 disp_ack,
    output rename_pkg::dispatch_pkt_t            disp_pkt,
    input  logic                                 release_en,
    input  logic [rename_pkg::PHYS_REG_BITS-1:0] release_preg
);
    import rename_pkg::*;

    fetch_pkt_t               head;
    logic                     not_empty;
    logic                     pop;
    logic [PHYS_REG_BITS-1:0] head_preg;
    logic                     has_free;
    logic                     alloc;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [PHYS_REG_BITS-1:0] ps1;
    logic [PHYS_REG_BITS-1:0] ps2;
    logic [PHYS_REG_BITS-1:0] old_pd;
    logic                     map_we;
    logic [4:0]               map_rd;
    logic [PHYS_REG_BITS-1:0] map_pd;
    logic                     idle;
    logic                     load;
    dispatch_pkt_t            pkt;

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) inst_queue_i (
        .clk, .rst, .fetch_req, .fetch_ack, .fetch_pkt, .pop, .head, .not_empty
    );

    free_list free_list_i (
        .clk, .rst, .alloc, .release_en, .release_preg, .head_preg, .has_free
    );

    rename_table rename_table_i (
        .clk, .rst, .rs1, .rs2, .rd, .ps1, .ps2, .old_pd, .map_we, .map_rd, .map_pd
    );

    rename_dispatch rename_dispatch_i (
        .clk, .rst, .head, .not_empty, .pop, .head_preg, .has_free, .alloc,
        .rs1, .rs2, .rd, .ps1, .ps2, .old_pd, .map_we, .map_rd, .map_pd,
        .idle, .load, .pkt
    );

    dispatch_port dispatch_port_i (
        .clk, .rst, .load, .pkt, .idle, .disp_req, .disp_ack, .disp_pkt
    );

endmodule

// File: test/rename_tb.sv
`timescale 1ns/100ps

module rename_tb;
    import rename_pkg::*;

    localparam int NUM_INSTS      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 40;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     fetch_req;
    logic                     fetch_ack;
    fetch_pkt_t               fetch_pkt;
    logic                     disp_req;
    logic                     disp_ack;
    dispatch_pkt_t            disp_pkt;
    logic                     release_en;
    logic [PHYS_REG_BITS-1:0] release_preg;

    // reference model of the rename state
    logic [PHYS_REG_BITS-1:0] model_map [NUM_ARCH_REGS];
    logic [PHYS_REG_BITS-1:0] model_free [$];
    logic [PHYS_REG_BITS-1:0] to_release [$];
    fetch_pkt_t               sent [$];

    logic [31:0] rng_state;
    logic        drain_done;
    int          reset_cycles;
    int          cycle;
    int          n_sent;
    int          n_rcv;
    int          fetch_state;
    int          fetch_gap;
    int          fetch_wait;
    int          max_fetch_wait;
    int          ack_state;
    int          ack_delay;
    int          drain_cycles;
    int          tail_cycles;

    rename_top #(
        .QUEUE_DEPTH(4)
    ) rename_top_i (
        .clk, .rst, .fetch_req, .fetch_ack, .fetch_pkt, .disp_req, .disp_ack, .disp_pkt,
        .release_en, .release_preg
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand_next();
        return int'(r[31:8]) % n;
    endfunction

    // low register numbers half the time, so dependencies show up often
    function automatic logic [4:0] pick_reg();
        if (rand_below(2) == 0)
            return 5'(rand_below(6));
        return 5'(rand_below(32));
    endfunction

    function automatic logic [31:0] make_inst();
        logic [6:0] op;
        logic [6:0] f7;
        case (rand_below(10))
            1:       op = op_imm;
            2:       op = op_load;
            3:       op = op_store;
            4:       op = op_br;
            5:       op = op_jal;
            6:       op = op_jalr;
            7:       op = op_lui;
            8:       op = op_auipc;
            default: op = op_reg;
        endcase
        case (rand_below(4))
            0:       f7 = 7'h00;
            1:       f7 = 7'h01;
            2:       f7 = 7'h20;
            default: f7 = 7'(rand_below(128));
        endcase
        return {f7, pick_reg(), pick_reg(), 3'(rand_below(8)), pick_reg(), op};
    endfunction

    function automatic rs_class_e expect_class(input logic [31:0] w);
        if (w[6:0] == op_reg && w[31:25] == 7'h01) begin
            if (w[14:12] < 3'd4)
                return cls_mul;
            return cls_div;
        end
        if (w[6:0] == op_br || w[6:0] == op_jal || w[6:0] == op_jalr)
            return cls_branch;
        if (w[6:0] == op_load || w[6:0] == op_store)
            return cls_mem;
        return cls_alu;
    endfunction

    // standard rv32 immediate layouts, taken straight from the word
    function automatic logic [31:0] expect_imm(input logic [31:0] w);
        case (w[6:0])
            op_imm, op_load, op_jalr: return {{20{w[31]}}, w[31:20]};
            op_store:                 return {{20{w[31]}}, w[31:25], w[11:7]};
            op_br:            return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            op_lui, op_auipc: return {w[31:12], 12'h000};
            op_jal:           return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:          return 32'h0;
        endcase
    endfunction

    function automatic logic expect_writes(input logic [31:0] w);
        return (w[11:7] != 5'd0) && (w[6:0] != op_store) && (w[6:0] != op_br);
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else begin
            $display("%s", what);
            stop_run();
        end
    endtask

    task automatic check_packet();
        fetch_pkt_t               exp;
        logic [31:0]              w;
        logic [4:0]               rd;
        logic [PHYS_REG_BITS-1:0] exp_pd;
        check_true(sent.size() > 0, "a packet was dispatched that was never fetched");
        exp = sent.pop_front();
        w = exp.inst;
        rd = w[11:7];
        check_hex("disp_pkt.inst", disp_pkt.inst, w);
        check_hex("disp_pkt.pc", disp_pkt.pc, exp.pc);
        check_hex("disp_pkt.order", disp_pkt.order, 64'(n_rcv));
        check_hex("disp_pkt.rs_class", disp_pkt.rs_class, expect_class(w));
        check_hex("disp_pkt.imm", disp_pkt.imm, expect_imm(w));
        check_hex("disp_pkt.rd_arch", disp_pkt.rd_arch, rd);
        check_hex("disp_pkt.ps1", disp_pkt.ps1, model_map[w[19:15]]);
        check_hex("disp_pkt.ps2", disp_pkt.ps2, model_map[w[24:20]]);
        check_hex("disp_pkt.writes_rd", disp_pkt.writes_rd, expect_writes(w));
        if (expect_writes(w)) begin
            check_true(model_free.size() > 0, "a register was allocated while none was free");
            exp_pd = model_free.pop_front();
            check_hex("disp_pkt.pd", disp_pkt.pd, exp_pd);
            check_hex("disp_pkt.old_pd", disp_pkt.old_pd, model_map[rd]);
            to_release.push_back(model_map[rd]);
            model_map[rd] = exp_pd;
        end else begin
            check_hex("disp_pkt.pd", disp_pkt.pd, 0);
            check_hex("disp_pkt.old_pd", disp_pkt.old_pd, 0);
        end
        n_rcv++;
    endtask

    // four-phase sender toward the queue
    task automatic drive_fetch();
        case (fetch_state)
            0: if (n_sent < NUM_INSTS) begin
                if (fetch_gap > 0) begin
                    fetch_gap--;
                end else begin
                    fetch_pkt = {make_inst(), 32'h1000 + 32'(n_sent * 4)};
                    fetch_req = 1'b1;
                    sent.push_back(fetch_pkt);
                    n_sent++;
                    fetch_wait = 0;
                    fetch_state = 1;
                end
            end
            1: if (fetch_ack) begin
                fetch_req = 1'b0;
                fetch_state = 2;
            end else begin
                fetch_wait++;
                if (fetch_wait > max_fetch_wait)
                    max_fetch_wait = fetch_wait;
            end
            default: if (!fetch_ack) begin
                fetch_state = 0;
                fetch_gap = rand_below(3);
            end
        endcase
    endtask

    // back end, slow acks for a stretch to fill the queue
    task automatic drive_backend();
        case (ack_state)
            0: if (disp_req) begin
                check_packet();
                if (n_rcv >= 200 && n_rcv < 260)
                    ack_delay = 6 + rand_below(10);
                else
                    ack_delay = rand_below(4);
                if (ack_delay == 0) begin
                    disp_ack = 1'b1;
                    ack_state = 2;
                end else begin
                    ack_state = 1;
                end
            end
            1: begin
                ack_delay--;
                if (ack_delay == 0) begin
                    disp_ack = 1'b1;
                    ack_state = 2;
                end
            end
            default: if (!disp_req) begin
                disp_ack = 1'b0;
                ack_state = 0;
            end
        endcase
    endtask

    task automatic drive_release();
        int idx;
        release_en = 1'b0;
        release_preg = '0;
        if (n_rcv >= 100 && !drain_done) begin
            // hold releases so the free list runs dry and dispatch stalls
            if (model_free.size() == 0) begin
                drain_cycles++;
                if (drain_cycles >= 30)
                    drain_done = 1'b1;
            end
        end else if (to_release.size() > 0 && rand_below(3) == 0) begin
            idx = rand_below(to_release.size());
            release_preg = to_release[idx];
            to_release.delete(idx);
            release_en = 1'b1;
            model_free.push_back(release_preg);
        end
    endtask

    initial begin
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_pkt = '0;
        disp_ack = 1'b0;
        release_en = 1'b0;
        release_preg = '0;
        rng_state = 32'ha003;
        drain_done = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++)
            model_map[i] = PHYS_REG_BITS'(i);
        for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++)
            model_free.push_back(PHYS_REG_BITS'(i));
    end

    always @(negedge clk) begin
        if (reset_cycles < 8) begin
            reset_cycles++;
            if (reset_cycles == 8)
                rst = 1'b0;
        end else begin
            cycle++;
            if (cycle >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles, %0d of %0d packets dispatched",
                         cycle, n_rcv, NUM_INSTS);
                stop_run();
            end else begin
                drive_fetch();
                drive_backend();
                drive_release();
                // a few quiet cycles catch any duplicate packet
                if (n_rcv == NUM_INSTS)
                    tail_cycles++;
                if (tail_cycles == 20) begin
                    check_true(sent.size() == 0, "fetched instructions were never dispatched");
                    check_true(max_fetch_wait > 2, "fetch was never held off by a full queue");
                    check_true(drain_done, "the free list never ran dry");
                    $display("=== PASS ===");
                    $finish;
                end
            end
        end
    end

endmodule

// File: files.f
logic/rename_pkg.sv
logic/inst_queue.sv
logic/free_list.sv
logic/rename_table.sv
logic/rename_dispatch.sv
logic/dispatch_port.sv
logic/rename_top.sv
test/rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# verilator build and run, the exit status carries the result
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal \
        -f files.f --top-module rename_tb -o rename_sim &&
    ./obj_dir/rename_sim ||
    { echo "rename simulation failed"; exit 1; }
